// File: Makefile
VERILATOR ?= verilator
TOP       := decodeStageTb
FILELIST  := tb.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0 \
             --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: logic/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             memStall,
    input  pipePkg::fetchT   fetch,
    input  pipePkg::bypassT  exeByp,
    input  pipePkg::bypassT  memByp,
    input  pipePkg::bypassT  wbByp,
    output pipePkg::issueT   issue,
    output isaPkg::wordT     altPc,
    output logic             altPcValid,
    output logic             sysNotify,
    output logic             freeze
);

    pipePkg::ctrlT ctrl;
    pipePkg::operandsT ops;
    isaPkg::regIdxT destReg;

    // Control decode
    instrDecoder uDecoder (
        .instr   (fetch.instr),
        .ctrl    (ctrl),
        .destReg (destReg)
    );

    // Register reads and forwarding, in parallel with decode
    operandFetch uOperands (
        .CLK     (CLK),
        .RESET   (RESET),
        .rs      (fetch.instr[isaPkg::RS_HI:isaPkg::RS_LO]),
        .rt      (fetch.instr[isaPkg::RT_HI:isaPkg::RT_LO]),
        .destReg (destReg),
        .exeByp  (exeByp),
        .memByp  (memByp),
        .wbByp   (wbByp),
        .ops     (ops)
    );

    // Registered hand-off to execute
    issueStage uIssue (
        .CLK        (CLK),
        .RESET      (RESET),
        .memStall   (memStall),
        .fetch      (fetch),
        .ctrl       (ctrl),
        .destReg    (destReg),
        .ops        (ops),
        .issue      (issue),
        .altPc      (altPc),
        .altPcValid (altPcValid),
        .sysNotify  (sysNotify),
        .freeze     (freeze)
    );

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  isaPkg::wordT   instr,
    output pipePkg::ctrlT  ctrl,
    output isaPkg::regIdxT destReg
);

    logic [5:0] opcode;
    logic [5:0] funct;
    isaPkg::regIdxT rt;
    isaPkg::regIdxT rd;

    assign opcode = instr[isaPkg::OP_HI:isaPkg::OP_LO];
    assign funct  = instr[isaPkg::FN_HI:isaPkg::FN_LO];
    assign rt     = instr[isaPkg::RT_HI:isaPkg::RT_LO];
    assign rd     = instr[isaPkg::RD_HI:isaPkg::RD_LO];

    always_comb begin
        // Unknown encodings fall through as an all-zero NOP
        ctrl = '0;
        case (opcode)
            isaPkg::OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    isaPkg::FN_ADDU: ctrl.aluCtrl = isaPkg::ALU_ADD;
                    isaPkg::FN_SUBU: ctrl.aluCtrl = isaPkg::ALU_SUB;
                    isaPkg::FN_AND:  ctrl.aluCtrl = isaPkg::ALU_AND;
                    isaPkg::FN_OR:   ctrl.aluCtrl = isaPkg::ALU_OR;
                    isaPkg::FN_XOR:  ctrl.aluCtrl = isaPkg::ALU_XOR;
                    isaPkg::FN_SLT:  ctrl.aluCtrl = isaPkg::ALU_SLT;
                    isaPkg::FN_SLL: begin
                        ctrl.aluCtrl  = isaPkg::ALU_SLL;
                        ctrl.useShamt = 1'b1;
                    end
                    isaPkg::FN_SRL: begin
                        ctrl.aluCtrl  = isaPkg::ALU_SRL;
                        ctrl.useShamt = 1'b1;
                    end
                    isaPkg::FN_JR: begin
                        // Register jump that writes nothing back
                        ctrl.jump     = 1'b1;
                        ctrl.jumpReg  = 1'b1;
                        ctrl.regWrite = 1'b0;
                        ctrl.aluCtrl  = isaPkg::ALU_ADD;
                    end
                    isaPkg::FN_SYSCALL: begin
                        ctrl.syscall  = 1'b1;
                        ctrl.regWrite = 1'b0;
                        ctrl.aluCtrl  = isaPkg::ALU_SYS;
                    end
                    default: ctrl = '0;
                endcase
            end
            isaPkg::OP_ADDIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_ADD;
            end
            isaPkg::OP_ANDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_AND;
            end
            isaPkg::OP_ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_OR;
            end
            isaPkg::OP_LUI: begin
                // Execute shifts the zero-extended immediate up
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_LUI;
            end
            isaPkg::OP_LW: begin
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_ADD;
            end
            isaPkg::OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_ADD;
            end
            isaPkg::OP_BEQ, isaPkg::OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.branchNe = (opcode == isaPkg::OP_BNE);
                ctrl.aluCtrl  = isaPkg::ALU_SUB;
            end
            isaPkg::OP_J: begin
                ctrl.jump    = 1'b1;
                ctrl.aluCtrl = isaPkg::ALU_ADD;
            end
            isaPkg::OP_JAL: begin
                // Link value is formed as 0 + PC+8 in execute
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = isaPkg::ALU_ADD;
            end
            default: ctrl = '0;
        endcase

        // Destination is rd, then the link register, then rt
        if (ctrl.regDst) begin
            destReg = rd;
        end else if (ctrl.link) begin
            destReg = isaPkg::LINK_REG;
        end else begin
            destReg = rt;
        end
    end

endmodule

// File: logic/isaPkg.sv
package isaPkg;

    ////////////////////
    // Basic types
    ////////////////////

    // Data or address word
    typedef logic [31:0] wordT;
    // Register index
    typedef logic [4:0] regIdxT;
    // ALU control code toward execute
    typedef logic [5:0] aluCtrlT;

    ////////////////////
    // Instruction fields
    ////////////////////

    localparam int OP_HI  = 31;
    localparam int OP_LO  = 26;
    localparam int RS_HI  = 25;
    localparam int RS_LO  = 21;
    localparam int RT_HI  = 20;
    localparam int RT_LO  = 16;
    localparam int RD_HI  = 15;
    localparam int RD_LO  = 11;
    localparam int SH_HI  = 10;
    localparam int SH_LO  = 6;
    localparam int FN_HI  = 5;
    localparam int FN_LO  = 0;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;
    // Jump index for J and JAL
    localparam int IDX_HI = 25;
    localparam int IDX_LO = 0;

    ////////////////////
    // Opcodes
    ////////////////////

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    ////////////////////
    // ALU codes
    ////////////////////

    // Zero is left free for a NOP
    localparam aluCtrlT ALU_ADD = 6'd1;
    localparam aluCtrlT ALU_SUB = 6'd2;
    localparam aluCtrlT ALU_AND = 6'd3;
    localparam aluCtrlT ALU_OR  = 6'd4;
    localparam aluCtrlT ALU_XOR = 6'd5;
    localparam aluCtrlT ALU_SLT = 6'd6;
    localparam aluCtrlT ALU_SLL = 6'd7;
    localparam aluCtrlT ALU_SRL = 6'd8;
    localparam aluCtrlT ALU_LUI = 6'd9;
    localparam aluCtrlT ALU_SYS = 6'd10;

    // Return address register for JAL
    localparam regIdxT LINK_REG = 5'd31;
    // Bubbles issued after a syscall
    localparam int SYS_DRAIN_CYCLES = 3;

endpackage

// File: logic/issueStage.sv
`timescale 1ns/100ps

module issueStage (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              memStall,
    input  pipePkg::fetchT    fetch,
    input  pipePkg::ctrlT     ctrl,
    input  isaPkg::regIdxT    destReg,
    input  pipePkg::operandsT ops,
    output pipePkg::issueT    issue,
    output isaPkg::wordT      altPc,
    output logic              altPcValid,
    output logic              sysNotify,
    output logic              freeze
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        NOTIFY
    } sysStateT;

    sysStateT sysState;
    logic [1:0] drainCnt;

    logic [15:0] imm;
    isaPkg::wordT immSext;
    isaPkg::wordT immExt;
    isaPkg::wordT brTarget;
    isaPkg::wordT jTarget;
    isaPkg::wordT target;
    logic taken;
    logic accept;
    logic takeSys;
    pipePkg::issueT nextIssue;

    ////////////////////
    // Operand selection
    ////////////////////

    assign imm     = fetch.instr[isaPkg::IMM_HI:isaPkg::IMM_LO];
    assign immSext = {{16{imm[15]}}, imm};
    assign immExt  = ctrl.signExt ? immSext : {16'h0000, imm};

    always_comb begin
        nextIssue         = '0;
        nextIssue.instr   = fetch.instr;
        nextIssue.pc      = fetch.pc;
        // Link instructions compute 0 + PC+8
        nextIssue.opA     = ctrl.link ? '0 : ops.rsVal;
        nextIssue.regA    = ctrl.link ? '0 : fetch.instr[isaPkg::RS_HI:isaPkg::RS_LO];
        if (ctrl.link) begin
            nextIssue.opB = fetch.pcPlus4 + 32'd4;
        end else if (ctrl.regDst || ctrl.branch) begin
            nextIssue.opB = ops.rtVal;
        end else begin
            nextIssue.opB = immExt;
        end
        nextIssue.regB      = ctrl.regDst ? fetch.instr[isaPkg::RT_HI:isaPkg::RT_LO] : '0;
        nextIssue.destReg   = destReg;
        nextIssue.storeData = ops.storeVal;
        // Writes to register zero are dropped here
        nextIssue.regWrite  = ctrl.regWrite && (destReg != '0);
        nextIssue.memRead   = ctrl.memRead;
        nextIssue.memWrite  = ctrl.memWrite;
        nextIssue.aluCtrl   = ctrl.aluCtrl;
        nextIssue.shamt     = ctrl.useShamt ? fetch.instr[isaPkg::SH_HI:isaPkg::SH_LO] : '0;
    end

    ////////////////////
    // Branch and jump
    ////////////////////

    assign brTarget = fetch.pcPlus4 + {immSext[29:0], 2'b00};
    assign jTarget  = {fetch.pcPlus4[31:28], fetch.instr[isaPkg::IDX_HI:isaPkg::IDX_LO], 2'b00};
    assign target   = ctrl.jumpReg ? ops.rsVal : (ctrl.jump ? jTarget : brTarget);
    assign taken    = ctrl.jump || (ctrl.branch && ((ops.rsVal == ops.rtVal) != ctrl.branchNe));

    ////////////////////
    // Syscall sequencer
    ////////////////////

    // Input is consumed only when idle
    assign accept    = (sysState == IDLE) && fetch.valid;
    assign takeSys   = accept && ctrl.syscall;
    assign sysNotify = (sysState == NOTIFY);
    // Fetch stays held until the sequencer is idle again
    assign freeze    = takeSys || (sysState != IDLE);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            issue      <= '0;
            altPc      <= '0;
            altPcValid <= 1'b0;
            sysState   <= IDLE;
            drainCnt   <= '0;
        end else if (!memStall) begin
            // Bubble for invalid input and for every sequencer cycle
            if (accept) begin
                issue      <= nextIssue;
                altPc      <= target;
                altPcValid <= taken;
            end else begin
                issue      <= '0;
                altPc      <= '0;
                altPcValid <= 1'b0;
            end
            case (sysState)
                IDLE: begin
                    if (takeSys) begin
                        sysState <= DRAIN;
                        drainCnt <= 2'(isaPkg::SYS_DRAIN_CYCLES - 1);
                    end
                end
                DRAIN: begin
                    if (drainCnt == '0) begin
                        sysState <= NOTIFY;
                    end else begin
                        drainCnt <= drainCnt - 2'd1;
                    end
                end
                default: sysState <= IDLE;
            endcase
        end
    end

    // Notification only ever lines up with a drained pipeline
    assert property (@(posedge CLK) disable iff (!RESET) sysNotify |-> (issue == '0))
        else $error("sysNotify raised with a live issue");

endmodule

// File: logic/operandFetch.sv
`timescale 1ns/100ps

module operandFetch (
    input  logic              CLK,
    input  logic              RESET,
    input  isaPkg::regIdxT    rs,
    input  isaPkg::regIdxT    rt,
    input  isaPkg::regIdxT    destReg,
    input  pipePkg::bypassT   exeByp,
    input  pipePkg::bypassT   memByp,
    input  pipePkg::bypassT   wbByp,
    output pipePkg::operandsT ops
);

    isaPkg::wordT rfA;
    isaPkg::wordT rfB;
    isaPkg::wordT rfC;

    // Store data is read through the destination index
    regFile uRegFile (
        .CLK   (CLK),
        .RESET (RESET),
        .rdA   (rs),
        .rdB   (rt),
        .rdC   (destReg),
        .dataA (rfA),
        .dataB (rfB),
        .dataC (rfC),
        .wb    (wbByp)
    );

    ////////////////////
    // Forwarding priority
    ////////////////////

    // EXE first, then MEM, then writeback, then the register file
    function automatic isaPkg::wordT pickSource(
        input isaPkg::regIdxT  idx,
        input isaPkg::wordT    rfVal,
        input pipePkg::bypassT exe,
        input pipePkg::bypassT mem,
        input pipePkg::bypassT wb
    );
        if (idx == '0) begin
            return '0;
        end else if (exe.valid && (exe.regIdx == idx)) begin
            return exe.data;
        end else if (mem.valid && (mem.regIdx == idx)) begin
            return mem.data;
        end else if (wb.valid && (wb.regIdx == idx)) begin
            // Same-cycle write not yet visible in the array
            return wb.data;
        end
        return rfVal;
    endfunction

    always_comb begin
        ops.rsVal    = pickSource(rs, rfA, exeByp, memByp, wbByp);
        ops.rtVal    = pickSource(rt, rfB, exeByp, memByp, wbByp);
        ops.storeVal = pickSource(destReg, rfC, exeByp, memByp, wbByp);
    end

endmodule

// File: logic/pipePkg.sv
package pipePkg;

    // Control bundle from the instruction decoder
    typedef struct packed {
        logic link;
        logic regDst;
        logic jump;
        logic branch;
        logic jumpReg;
        logic signExt;
        logic memRead;
        logic memWrite;
        logic regWrite;
        logic syscall;
        logic useShamt;
        // Set for BNE, clear for BEQ
        logic branchNe;
        isaPkg::aluCtrlT aluCtrl;
    } ctrlT;

    // Forwarded register values
    typedef struct packed {
        isaPkg::wordT rsVal;
        isaPkg::wordT rtVal;
        isaPkg::wordT storeVal;
    } operandsT;

    // One forwarding source, also the register file write port
    typedef struct packed {
        logic valid;
        isaPkg::regIdxT regIdx;
        isaPkg::wordT data;
    } bypassT;

    // Instruction from fetch
    typedef struct packed {
        isaPkg::wordT instr;
        isaPkg::wordT pc;
        isaPkg::wordT pcPlus4;
        logic valid;
    } fetchT;

    // Bundle toward execute
    typedef struct packed {
        isaPkg::wordT instr;
        isaPkg::wordT pc;
        isaPkg::wordT opA;
        isaPkg::wordT opB;
        isaPkg::regIdxT regA;
        isaPkg::regIdxT regB;
        isaPkg::regIdxT destReg;
        isaPkg::wordT storeData;
        logic regWrite;
        logic memRead;
        logic memWrite;
        isaPkg::aluCtrlT aluCtrl;
        logic [4:0] shamt;
    } issueT;

endpackage

// File: logic/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic             CLK,
    input  logic             RESET,
    input  isaPkg::regIdxT   rdA,
    input  isaPkg::regIdxT   rdB,
    input  isaPkg::regIdxT   rdC,
    output isaPkg::wordT     dataA,
    output isaPkg::wordT     dataB,
    output isaPkg::wordT     dataC,
    input  pipePkg::bypassT  wb
);

    isaPkg::wordT regs [32];

    // Single write port from writeback
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            regs <= '{default: '0};
        end else if (wb.valid && (wb.regIdx != '0)) begin
            regs[wb.regIdx] <= wb.data;
        end
    end

    // Asynchronous reads with register zero hardwired
    assign dataA = (rdA == '0) ? '0 : regs[rdA];
    assign dataB = (rdB == '0) ? '0 : regs[rdB];
    assign dataC = (rdC == '0) ? '0 : regs[rdC];

    // A valid writeback needs a known index
    assert property (@(posedge CLK) disable iff (!RESET) wb.valid |-> !$isunknown(wb.regIdx))
        else $error("writeback index is unknown");

endmodule

// File: tb.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/operandFetch.sv
logic/issueStage.sv
logic/decodeStage.sv
test/clockGen.sv
test/decodeStageTb.sv

// File: test/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic CLK,
    output logic RESET
);

    // Free-running clock, first rising edge at half a period
    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Active-low reset, released on a falling edge
    initial begin
        RESET = 1'b0;
        #(PERIOD * RESET_CYCLES);
        RESET = 1'b1;
    end

endmodule

// File: test/decodeStageTb.sv
`timescale 1ns/100ps

module decodeStageTb;

    localparam int PERIOD        = 40;
    localparam int NUM_CYCLES    = 3000;
    // Reset, final compare and slack
    localparam int MARGIN_CYCLES = 50;

    // Expected registered outputs of one edge
    typedef struct packed {
        pipePkg::issueT issue;
        isaPkg::wordT   altPc;
        logic           altPcValid;
    } expectT;

    logic              CLK;
    logic              RESET;
    logic              memStall;
    pipePkg::fetchT    fetch;
    pipePkg::bypassT   exeByp;
    pipePkg::bypassT   memByp;
    pipePkg::bypassT   wbByp;
    pipePkg::issueT    issue;
    isaPkg::wordT      altPc;
    logic              altPcValid;
    logic              sysNotify;
    logic              freeze;

    logic [15:0]  lfsrState;
    isaPkg::wordT shadow [32];
    expectT       expected;
    // Syscall model phase is 0 idle, 1 drain or 2 notify
    int           sysPhase;
    int           drainLeft;
    int           sysSeen;
    int           takenSeen;

    clockGen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) uClock (
        .CLK   (CLK),
        .RESET (RESET)
    );

    decodeStage dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .memStall   (memStall),
        .fetch      (fetch),
        .exeByp     (exeByp),
        .memByp     (memByp),
        .wbByp      (wbByp),
        .issue      (issue),
        .altPc      (altPc),
        .altPcValid (altPcValid),
        .sysNotify  (sysNotify),
        .freeze     (freeze)
    );

    ////////////////////
    // Random source
    ////////////////////

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic isSyscall(input isaPkg::wordT instr);
        return (instr[31:26] == isaPkg::OP_RTYPE) && (instr[5:0] == isaPkg::FN_SYSCALL);
    endfunction

    // EXE, then MEM, then writeback, then shadow registers
    function automatic isaPkg::wordT forwarded(input isaPkg::regIdxT idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (exeByp.valid && (exeByp.regIdx == idx)) begin
            return exeByp.data;
        end
        if (memByp.valid && (memByp.regIdx == idx)) begin
            return memByp.data;
        end
        if (wbByp.valid && (wbByp.regIdx == idx)) begin
            return wbByp.data;
        end
        return shadow[idx];
    endfunction

    function automatic expectT referenceDecode(input pipePkg::fetchT f);
        expectT         e;
        logic [5:0]     op;
        logic [5:0]     fn;
        isaPkg::regIdxT rs;
        isaPkg::regIdxT rt;
        isaPkg::regIdxT rd;
        logic [15:0]    imm;
        isaPkg::wordT   sext;
        isaPkg::wordT   rsV;
        isaPkg::wordT   rtV;
        logic           isR;
        logic           isBr;
        logic           isJ;
        logic           isJr;
        logic           link;
        logic           wr;
        logic           useSh;
        op   = f.instr[31:26];
        fn   = f.instr[5:0];
        rs   = f.instr[25:21];
        rt   = f.instr[20:16];
        rd   = f.instr[15:11];
        imm  = f.instr[15:0];
        sext = {{16{imm[15]}}, imm};
        rsV  = forwarded(rs);
        rtV  = forwarded(rt);
        isR  = (op == isaPkg::OP_RTYPE);
        isBr = (op == isaPkg::OP_BEQ) || (op == isaPkg::OP_BNE);
        isJ  = (op == isaPkg::OP_J) || (op == isaPkg::OP_JAL);
        link = (op == isaPkg::OP_JAL);
        isJr = isR && (fn == isaPkg::FN_JR);
        wr    = 1'b1;
        useSh = 1'b0;
        e = '0;
        case (op)
            isaPkg::OP_RTYPE: begin
                case (fn)
                    isaPkg::FN_ADDU: e.issue.aluCtrl = isaPkg::ALU_ADD;
                    isaPkg::FN_SUBU: e.issue.aluCtrl = isaPkg::ALU_SUB;
                    isaPkg::FN_AND:  e.issue.aluCtrl = isaPkg::ALU_AND;
                    isaPkg::FN_OR:   e.issue.aluCtrl = isaPkg::ALU_OR;
                    isaPkg::FN_XOR:  e.issue.aluCtrl = isaPkg::ALU_XOR;
                    isaPkg::FN_SLT:  e.issue.aluCtrl = isaPkg::ALU_SLT;
                    isaPkg::FN_SLL: begin
                        e.issue.aluCtrl = isaPkg::ALU_SLL;
                        useSh = 1'b1;
                    end
                    isaPkg::FN_SRL: begin
                        e.issue.aluCtrl = isaPkg::ALU_SRL;
                        useSh = 1'b1;
                    end
                    isaPkg::FN_JR: begin
                        e.issue.aluCtrl = isaPkg::ALU_ADD;
                        wr = 1'b0;
                    end
                    isaPkg::FN_SYSCALL: begin
                        e.issue.aluCtrl = isaPkg::ALU_SYS;
                        wr = 1'b0;
                    end
                    default: wr = 1'b0;
                endcase
            end
            isaPkg::OP_ADDIU, isaPkg::OP_LW, isaPkg::OP_JAL: e.issue.aluCtrl = isaPkg::ALU_ADD;
            isaPkg::OP_ANDI: e.issue.aluCtrl = isaPkg::ALU_AND;
            isaPkg::OP_ORI:  e.issue.aluCtrl = isaPkg::ALU_OR;
            isaPkg::OP_LUI:  e.issue.aluCtrl = isaPkg::ALU_LUI;
            isaPkg::OP_SW, isaPkg::OP_J: begin
                e.issue.aluCtrl = isaPkg::ALU_ADD;
                wr = 1'b0;
            end
            isaPkg::OP_BEQ, isaPkg::OP_BNE: begin
                e.issue.aluCtrl = isaPkg::ALU_SUB;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        e.issue.instr    = f.instr;
        e.issue.pc       = f.pc;
        e.issue.memRead  = (op == isaPkg::OP_LW);
        e.issue.memWrite = (op == isaPkg::OP_SW);
        // Link value is 0 + PC+8
        e.issue.opA  = link ? '0 : rsV;
        e.issue.regA = link ? 5'd0 : rs;
        if (link) begin
            e.issue.opB = f.pcPlus4 + 32'd4;
        end else if (isR || isBr) begin
            e.issue.opB = rtV;
        end else if ((op == isaPkg::OP_ADDIU) || (op == isaPkg::OP_LW)
                     || (op == isaPkg::OP_SW)) begin
            e.issue.opB = sext;
        end else begin
            e.issue.opB = {16'h0000, imm};
        end
        e.issue.regB      = isR ? rt : 5'd0;
        e.issue.destReg   = isR ? rd : (link ? isaPkg::LINK_REG : rt);
        e.issue.storeData = forwarded(e.issue.destReg);
        e.issue.regWrite  = wr && (e.issue.destReg != 5'd0);
        e.issue.shamt     = useSh ? f.instr[10:6] : 5'd0;
        // Target is registered even when nothing is taken
        if (isJr) begin
            e.altPc = rsV;
        end else if (isJ) begin
            e.altPc = {f.pcPlus4[31:28], f.instr[25:0], 2'b00};
        end else begin
            e.altPc = f.pcPlus4 + {sext[29:0], 2'b00};
        end
        e.altPcValid = isJ || isJr || (isBr && ((rsV == rtV) != (op == isaPkg::OP_BNE)));
        return e;
    endfunction

    // Steps the model over one rising edge using the inputs the DUT samples there
    task automatic modelEdge();
        if (!memStall) begin
            if ((sysPhase == 0) && fetch.valid) begin
                expected = referenceDecode(fetch);
                if (expected.altPcValid) begin
                    takenSeen++;
                end
                if (isSyscall(fetch.instr)) begin
                    sysPhase  = 1;
                    drainLeft = isaPkg::SYS_DRAIN_CYCLES;
                    sysSeen++;
                end
            end else begin
                expected = '0;
                if (sysPhase == 1) begin
                    drainLeft--;
                    if (drainLeft == 0) begin
                        sysPhase = 2;
                    end
                end else if (sysPhase == 2) begin
                    sysPhase = 0;
                end
            end
        end
        // Writeback lands even while stalled
        if (wbByp.valid && (wbByp.regIdx != 5'd0)) begin
            shadow[wbByp.regIdx] = wbByp.data;
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Small register range so bypasses overlap often
    function automatic isaPkg::wordT randomInstr();
        logic [31:0] r;
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  fn;
        logic [5:0]  op;
        r = takeBits(4);
        kind = r[3:0];
        r = takeBits(3);
        rs = {2'b00, r[2:0]};
        r = takeBits(3);
        rt = {2'b00, r[2:0]};
        r = takeBits(3);
        rd = {2'b00, r[2:0]};
        r = takeBits(5);
        sh = r[4:0];
        r = takeBits(16);
        imm = r[15:0];
        r = takeBits(3);
        case (r[2:0])
            3'd0: fn = isaPkg::FN_ADDU;
            3'd1: fn = isaPkg::FN_SUBU;
            3'd2: fn = isaPkg::FN_AND;
            3'd3: fn = isaPkg::FN_OR;
            3'd4: fn = isaPkg::FN_XOR;
            3'd5: fn = isaPkg::FN_SLT;
            3'd6: fn = isaPkg::FN_SLL;
            default: fn = isaPkg::FN_SRL;
        endcase
        r = takeBits(2);
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: return {isaPkg::OP_RTYPE, rs, rt, rd, sh, fn};
            4'd5, 4'd15: return {isaPkg::OP_ADDIU, rs, rt, imm};
            4'd6: return {isaPkg::OP_ANDI, rs, rt, imm};
            4'd7: return {isaPkg::OP_ORI, rs, rt, imm};
            4'd8: return {isaPkg::OP_LUI, rs, rt, imm};
            4'd9: return {isaPkg::OP_LW, rs, rt, imm};
            4'd10: return {isaPkg::OP_SW, rs, rt, imm};
            4'd11: begin
                // Half of the branches compare a register with itself
                op = r[0] ? isaPkg::OP_BNE : isaPkg::OP_BEQ;
                return {op, rs, (r[1] ? rs : rt), imm};
            end
            4'd12: begin
                op = r[0] ? isaPkg::OP_JAL : isaPkg::OP_J;
                return {op, rs, rt, imm};
            end
            4'd13: return {isaPkg::OP_RTYPE, rs, 15'd0, isaPkg::FN_JR};
            default: return {isaPkg::OP_RTYPE, rs, rt, rd, sh, isaPkg::FN_SYSCALL};
        endcase
    endfunction

    function automatic pipePkg::bypassT randomBypass();
        pipePkg::bypassT b;
        logic [31:0]     r;
        r = takeBits(1);
        b.valid = r[0];
        r = takeBits(3);
        b.regIdx = {2'b00, r[2:0]};
        b.data = takeBits(32);
        return b;
    endfunction

    task automatic driveRandom();
        pipePkg::fetchT f;
        logic [31:0]    r;
        f.instr = randomInstr();
        r = takeBits(30);
        f.pc = {r[29:0], 2'b00};
        f.pcPlus4 = f.pc + 32'd4;
        r = takeBits(3);
        f.valid = (r[2:0] != 3'd0);
        fetch  <= f;
        exeByp <= randomBypass();
        memByp <= randomBypass();
        wbByp  <= randomBypass();
        r = takeBits(2);
        memStall <= (r[1:0] == 2'd0);
    endtask

    ////////////////////
    // Checking
    ////////////////////

    task automatic checkValue(input string what, input logic [191:0] got,
                              input logic [191:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "Output mismatch on %s", what);
        end
    endtask

    // Registered outputs are stable at the falling edge
    initial begin : compareOutputs
        logic expFreeze;
        wait (RESET === 1'b1);
        forever begin
            @(negedge CLK);
            expFreeze = ((sysPhase == 0) && fetch.valid && isSyscall(fetch.instr))
                        || (sysPhase != 0);
            checkValue("issue", 192'(issue), 192'(expected.issue));
            checkValue("altPc", 192'(altPc), 192'(expected.altPc));
            checkValue("altPcValid", 192'(altPcValid), 192'(expected.altPcValid));
            checkValue("sysNotify", 192'(sysNotify), 192'(sysPhase == 2));
            checkValue("freeze", 192'(freeze), 192'(expFreeze));
        end
    end

    initial begin : watchdog
        #((NUM_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("Verification failed");
        $fatal(1, "Timeout: the run did not finish within %0d cycles",
               NUM_CYCLES + MARGIN_CYCLES);
    end

    initial begin : stimulus
        lfsrState = 16'd91;
        shadow    = '{default: '0};
        expected  = '0;
        sysPhase  = 0;
        drainLeft = 0;
        sysSeen   = 0;
        takenSeen = 0;
        memStall  = 1'b0;
        fetch     = '0;
        exeByp    = '0;
        memByp    = '0;
        wbByp     = '0;
        wait (RESET === 1'b1);
        repeat (NUM_CYCLES) begin
            @(posedge CLK);
            modelEdge();
            driveRandom();
        end
        // Let the last compare run before the next edge
        @(negedge CLK);
        #1;
        if ((sysSeen == 0) || (takenSeen == 0)) begin
            $display("Verification failed");
            $fatal(1, "The stimulus never reached a syscall or a taken branch");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
